// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert
TOP      := cache_store_tb
FILELIST := compile.f
OBJDIR   := obj_dir

BIN     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf $(OBJDIR)

// File: cache_hit_check.sv
`timescale 1ns/1ns
`default_nettype none

module cache_hit_check
    import cache_pkg::*;
(
    input  logic  clk_in,
    input  logic  reset_in,

    input  logic  a_access_en,
    input  tag_t  a_tag,
    input  tag_t  a_stored_tag,
    input  logic  a_tag_valid,
    input  data_t a_entry,
    output logic  a_hit,
    output logic  a_read_valid,
    output data_t a_read_data,

    input  logic  b_access_en,
    input  tag_t  b_tag,
    input  tag_t  b_stored_tag,
    input  logic  b_tag_valid,
    input  data_t b_entry,
    output logic  b_hit,
    output logic  b_read_valid,
    output data_t b_read_data
);

    logic [1:0] access_q;
    tag_t       a_tag_q;
    tag_t       b_tag_q;

    // The strobes line up with the block RAM outputs one cycle later.
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            access_q <= '0;
        end
        else
        begin
            access_q <= {b_access_en, a_access_en};
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (a_access_en)
        begin
            a_tag_q <= a_tag;
        end
        if (b_access_en)
        begin
            b_tag_q <= b_tag;
        end
    end

    // ------------------------------
    // Result merge
    // ------------------------------

    assign a_read_valid = access_q[0];
    assign b_read_valid = access_q[1];

    assign a_hit = access_q[0] && a_tag_valid && (a_stored_tag == a_tag_q);
    assign b_hit = access_q[1] && b_tag_valid && (b_stored_tag == b_tag_q);

    assign a_read_data = a_entry;
    assign b_read_data = b_entry;

endmodule

`default_nettype wire

// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

    // ------------------------------
    // Cache geometry
    // ------------------------------

    // Bits in one write lane of a block RAM entry.
    localparam int byte_len = 8;

    localparam int num_set_default = 64;
    localparam int data_width_default = 64;
    localparam int tag_width_default = 8;

    localparam int index_width = $clog2(num_set_default);

    // ------------------------------
    // Request and entry types
    // ------------------------------

    typedef logic [index_width-1:0] index_t;

    typedef logic [tag_width_default-1:0] tag_t;

    typedef logic [data_width_default-1:0] data_t;

    // One enable per byte lane of a data entry.
    typedef logic [data_width_default/byte_len-1:0] byte_mask_t;

    // The tag sits above the set index.
    typedef logic [tag_width_default+index_width-1:0] addr_t;

endpackage

`default_nettype wire

// File: cache_store.sv
`timescale 1ns/1ns
`default_nettype none

module cache_store
    import cache_pkg::*;
#(
    parameter int num_set = num_set_default,
    parameter int data_width = data_width_default
)
(
    input  logic                         clk_in,
    input  logic                         reset_in,

    input  logic                         a_access_en,
    input  logic [data_width/byte_len-1:0] a_byte_mask,
    input  addr_t                        a_addr,
    input  logic [data_width-1:0]        a_write_data,
    output logic [data_width-1:0]        a_read_data,
    output logic                         a_hit,
    output logic                         a_read_valid,

    input  logic                         b_access_en,
    input  logic [data_width/byte_len-1:0] b_byte_mask,
    input  addr_t                        b_addr,
    input  logic [data_width-1:0]        b_write_data,
    output logic [data_width-1:0]        b_read_data,
    output logic                         b_hit,
    output logic                         b_read_valid
);

    index_t a_index;
    index_t b_index;
    tag_t   a_tag;
    tag_t   b_tag;
    tag_t   a_stored_tag;
    tag_t   b_stored_tag;
    logic   a_tag_valid;
    logic   b_tag_valid;
    data_t  a_entry;
    data_t  b_entry;
    logic   a_data_valid;
    logic   b_data_valid;

    // Address split.
    assign a_index = index_t'(a_addr);
    assign b_index = index_t'(b_addr);
    assign a_tag = a_addr[$bits(addr_t)-1 -: $bits(tag_t)];
    assign b_tag = b_addr[$bits(addr_t)-1 -: $bits(tag_t)];

    // ------------------------------
    // Tag and data arrays
    // ------------------------------

    // A fill of any byte rewrites the whole tag.
    dual_port_blockram #(
        .entry_t          (tag_t),
        .num_set          (num_set),
        .with_valid_array ("Yes")
    ) i_tag_array (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .a_access_en   (a_access_en),
        .a_write_en    (|a_byte_mask),
        .a_set_addr    (a_index),
        .a_write_entry (a_tag),
        .a_read_entry  (a_stored_tag),
        .a_read_valid  (a_tag_valid),
        .b_access_en   (b_access_en),
        .b_write_en    (|b_byte_mask),
        .b_set_addr    (b_index),
        .b_write_entry (b_tag),
        .b_read_entry  (b_stored_tag),
        .b_read_valid  (b_tag_valid)
    );

    dual_port_blockram #(
        .entry_t          (data_t),
        .num_set          (num_set),
        .with_valid_array ("No")
    ) i_data_array (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .a_access_en   (a_access_en),
        .a_write_en    (a_byte_mask),
        .a_set_addr    (a_index),
        .a_write_entry (a_write_data),
        .a_read_entry  (a_entry),
        .a_read_valid  (a_data_valid),
        .b_access_en   (b_access_en),
        .b_write_en    (b_byte_mask),
        .b_set_addr    (b_index),
        .b_write_entry (b_write_data),
        .b_read_entry  (b_entry),
        .b_read_valid  (b_data_valid)
    );

    // The data array only drops its valid during reset.
    cache_hit_check i_hit_check (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .a_access_en  (a_access_en),
        .a_tag        (a_tag),
        .a_stored_tag (a_stored_tag),
        .a_tag_valid  (a_tag_valid & a_data_valid),
        .a_entry      (a_entry),
        .a_hit        (a_hit),
        .a_read_valid (a_read_valid),
        .a_read_data  (a_read_data),
        .b_access_en  (b_access_en),
        .b_tag        (b_tag),
        .b_stored_tag (b_stored_tag),
        .b_tag_valid  (b_tag_valid & b_data_valid),
        .b_entry      (b_entry),
        .b_hit        (b_hit),
        .b_read_valid (b_read_valid),
        .b_read_data  (b_read_data)
    );

endmodule

`default_nettype wire

// File: cache_store_sva.sv
`timescale 1ns/1ns
`default_nettype none

module cache_store_sva
(
    input logic clk_in,
    input logic reset_in,
    input logic a_access_en,
    input logic a_hit,
    input logic a_read_valid,
    input logic b_access_en,
    input logic b_hit,
    input logic b_read_valid
);

    // A hit is only ever reported alongside a returned access.
    a_hit_has_valid: assert property (@(posedge clk_in) disable iff (reset_in)
        a_hit |-> a_read_valid) else $error("a_hit raised without a_read_valid");
    b_hit_has_valid: assert property (@(posedge clk_in) disable iff (reset_in)
        b_hit |-> b_read_valid) else $error("b_hit raised without b_read_valid");

    // The result strobe trails the access strobe by exactly one cycle.
    a_valid_follows_access: assert property (@(posedge clk_in) disable iff (reset_in)
        a_read_valid == $past(a_access_en)) else $error("a_read_valid out of step");
    b_valid_follows_access: assert property (@(posedge clk_in) disable iff (reset_in)
        b_read_valid == $past(b_access_en)) else $error("b_read_valid out of step");

endmodule

bind cache_store cache_store_sva i_cache_store_sva (.*);

`default_nettype wire

// File: cache_store_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cache_store_tb
    import cache_pkg::*;
;

    localparam int timeout_cycles = 20;

    logic       clk_in;
    logic       reset_in;
    logic       a_access_en;
    byte_mask_t a_byte_mask;
    addr_t      a_addr;
    data_t      a_write_data;
    data_t      a_read_data;
    logic       a_hit;
    logic       a_read_valid;
    logic       b_access_en;
    byte_mask_t b_byte_mask;
    addr_t      b_addr;
    data_t      b_write_data;
    data_t      b_read_data;
    logic       b_hit;
    logic       b_read_valid;

    // Reference model of the cache contents, indexed by set.
    data_t model_data [num_set_default];
    tag_t  model_tag [num_set_default];
    logic  model_valid [num_set_default];

    data_t a_res_data;
    data_t b_res_data;
    logic  a_res_hit;
    logic  b_res_hit;
    addr_t base_addr;
    int    errors;
    int    checks;

    cache_store #(
        .num_set    (num_set_default),
        .data_width (data_width_default)
    ) i_cache_store (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .a_access_en  (a_access_en),
        .a_byte_mask  (a_byte_mask),
        .a_addr       (a_addr),
        .a_write_data (a_write_data),
        .a_read_data  (a_read_data),
        .a_hit        (a_hit),
        .a_read_valid (a_read_valid),
        .b_access_en  (b_access_en),
        .b_byte_mask  (b_byte_mask),
        .b_addr       (b_addr),
        .b_write_data (b_write_data),
        .b_read_data  (b_read_data),
        .b_hit        (b_hit),
        .b_read_valid (b_read_valid)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    // ------------------------------
    // Model and compare helpers
    // ------------------------------

    // The tag is the part of the address above the set index.
    function automatic logic expect_hit(input addr_t adr);
        index_t idx;
        idx = index_t'(adr);
        return model_valid[idx] && (model_tag[idx] == adr[$bits(addr_t)-1 -: $bits(tag_t)]);
    endfunction

    function automatic void fill_model(input addr_t adr, input byte_mask_t mask,
                                       input data_t wdata);
        index_t idx;
        idx = index_t'(adr);
        for (int l = 0; l < $bits(byte_mask_t); l++)
            if (mask[l])
                model_data[idx][l*byte_len +: byte_len] = wdata[l*byte_len +: byte_len];
        if (|mask)
        begin
            model_tag[idx] = adr[$bits(addr_t)-1 -: $bits(tag_t)];
            model_valid[idx] = 1'b1;
        end
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    // One access cycle on either or both ports, then wait for the results.
    task automatic access(input logic a_en, input byte_mask_t a_mask, input addr_t a_adr,
                          input data_t a_wdata, input logic b_en, input byte_mask_t b_mask,
                          input addr_t b_adr, input data_t b_wdata);
        int cycles;
        @(posedge clk_in);
        a_access_en <= a_en;
        a_byte_mask <= a_mask;
        a_addr <= a_adr;
        a_write_data <= a_wdata;
        b_access_en <= b_en;
        b_byte_mask <= b_mask;
        b_addr <= b_adr;
        b_write_data <= b_wdata;
        @(posedge clk_in);
        a_access_en <= 1'b0;
        b_access_en <= 1'b0;
        cycles = 0;
        do
        begin
            @(negedge clk_in);
            cycles++;
        end
        while (((a_en && !a_read_valid) || (b_en && !b_read_valid)) && cycles < timeout_cycles);
        if (cycles > 1)
        begin
            errors++;
            $display("Read result did not arrive one cycle after the access (%0d cycles)", cycles);
        end
        a_res_data = a_read_data;
        a_res_hit = a_hit;
        b_res_data = b_read_data;
        b_res_hit = b_hit;
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic test_reset_miss();
        addr_t adr_a;
        addr_t adr_b;
        for (int n = 0; n < 4; n++)
        begin
            adr_a = addr_t'($urandom);
            adr_b = addr_t'($urandom);
            access(1'b1, '0, adr_a, '0, 1'b1, '0, adr_b, '0);
            check_flag("a_hit", a_res_hit, expect_hit(adr_a));
            check_flag("b_hit", b_res_hit, expect_hit(adr_b));
        end
    endtask

    task automatic test_fill_then_read();
        data_t wdata;
        base_addr = addr_t'($urandom);
        wdata = {$urandom, $urandom};
        access(1'b1, '1, base_addr, wdata, 1'b0, '0, '0, '0);
        fill_model(base_addr, '1, wdata);
        access(1'b0, '0, '0, '0, 1'b1, '0, base_addr, '0);
        check_flag("b_hit", b_res_hit, expect_hit(base_addr));
        check_data("b_read_data", b_res_data, model_data[index_t'(base_addr)]);
    endtask

    task automatic test_tag_mismatch();
        addr_t other;
        other = base_addr + (addr_t'(1) << $bits(index_t));
        access(1'b1, '0, other, '0, 1'b0, '0, '0, '0);
        check_flag("a_hit", a_res_hit, expect_hit(other));
        check_data("a_read_data", a_res_data, model_data[index_t'(other)]);
    endtask

    task automatic test_partial_fill();
        data_t wdata;
        wdata = {$urandom, $urandom};
        access(1'b0, '0, '0, '0, 1'b1, 8'b1010_0110, base_addr, wdata);
        fill_model(base_addr, 8'b1010_0110, wdata);
        access(1'b1, '0, base_addr, '0, 1'b0, '0, '0, '0);
        check_flag("a_hit", a_res_hit, expect_hit(base_addr));
        check_data("a_read_data", a_res_data, model_data[index_t'(base_addr)]);
    endtask

    // Port A refills the set under a new tag while port B reads it.
    task automatic test_read_write_collision();
        addr_t other;
        data_t wdata;
        data_t old_data;
        logic  old_hit_a;
        logic  old_hit_b;
        other = base_addr + (addr_t'(3) << $bits(index_t));
        wdata = {$urandom, $urandom};
        old_data = model_data[index_t'(base_addr)];
        old_hit_a = expect_hit(other);
        old_hit_b = expect_hit(base_addr);
        access(1'b1, '1, other, wdata, 1'b1, '0, base_addr, '0);
        check_flag("a_hit", a_res_hit, old_hit_a);
        check_data("a_read_data", a_res_data, old_data);
        check_flag("b_hit", b_res_hit, old_hit_b);
        check_data("b_read_data", b_res_data, old_data);
        fill_model(other, '1, wdata);
        access(1'b0, '0, '0, '0, 1'b1, '0, base_addr, '0);
        check_flag("b_hit", b_res_hit, expect_hit(base_addr));
        check_data("b_read_data", b_res_data, model_data[index_t'(base_addr)]);
    endtask

    task automatic test_dual_fill();
        addr_t adr_a;
        addr_t adr_b;
        data_t wdata_a;
        data_t wdata_b;
        adr_a = addr_t'($urandom);
        adr_b = adr_a ^ addr_t'(1);
        wdata_a = {$urandom, $urandom};
        wdata_b = {$urandom, $urandom};
        access(1'b1, '1, adr_a, wdata_a, 1'b1, '1, adr_b, wdata_b);
        fill_model(adr_a, '1, wdata_a);
        fill_model(adr_b, '1, wdata_b);
        access(1'b1, '0, adr_b, '0, 1'b1, '0, adr_a, '0);
        check_flag("a_hit", a_res_hit, expect_hit(adr_b));
        check_data("a_read_data", a_res_data, model_data[index_t'(adr_b)]);
        check_flag("b_hit", b_res_hit, expect_hit(adr_a));
        check_data("b_read_data", b_res_data, model_data[index_t'(adr_a)]);
    endtask

    initial
    begin
        void'($urandom(32'h76d62246));
        errors = 0;
        checks = 0;
        reset_in = 1'b1;
        a_access_en = 1'b0;
        a_byte_mask = '0;
        a_addr = '0;
        a_write_data = '0;
        b_access_en = 1'b0;
        b_byte_mask = '0;
        b_addr = '0;
        b_write_data = '0;
        for (int s = 0; s < num_set_default; s++)
            model_valid[s] = 1'b0;
        repeat (10) @(posedge clk_in);
        reset_in <= 1'b0;

        test_reset_miss();
        test_fill_then_read();
        test_tag_mismatch();
        test_partial_fill();
        test_read_write_collision();
        test_dual_fill();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
cache_pkg.sv
dual_port_blockram.sv
cache_hit_check.sv
cache_store.sv
cache_store_sva.sv
cache_store_tb.sv

// File: dual_port_blockram.sv
`timescale 1ns/1ns
`default_nettype none

module dual_port_blockram
    import cache_pkg::*;
#(
    parameter type entry_t = data_t,
    parameter int num_set = num_set_default,
    parameter string with_valid_array = "Yes",
    localparam int entry_width = $bits(entry_t),
    localparam int num_lane = (entry_width + byte_len - 1) / byte_len,
    localparam int set_width = $clog2(num_set)
)
(
    input  logic                 clk_in,
    input  logic                 reset_in,

    input  logic                 a_access_en,
    input  logic [num_lane-1:0]  a_write_en,
    input  logic [set_width-1:0] a_set_addr,
    input  entry_t               a_write_entry,
    output entry_t               a_read_entry,
    output logic                 a_read_valid,

    input  logic                 b_access_en,
    input  logic [num_lane-1:0]  b_write_en,
    input  logic [set_width-1:0] b_set_addr,
    input  entry_t               b_write_entry,
    output entry_t               b_read_entry,
    output logic                 b_read_valid
);

    // Entries are stored padded up to a whole number of lanes.
    localparam int padded_width = num_lane * byte_len;

    logic [padded_width-1:0] mem [num_set];

    logic [1:0]              access_en;
    logic [num_lane-1:0]     write_en [2];
    logic [set_width-1:0]    set_addr [2];
    logic [padded_width-1:0] write_word [2];
    logic [padded_width-1:0] read_word [2];

    assign access_en = {b_access_en, a_access_en};

    assign write_en[0] = a_write_en;
    assign write_en[1] = b_write_en;

    assign set_addr[0] = a_set_addr;
    assign set_addr[1] = b_set_addr;

    assign write_word[0] = padded_width'(a_write_entry);
    assign write_word[1] = padded_width'(b_write_entry);

    // ------------------------------
    // Storage, read-first
    // ------------------------------

    // The read samples the entry before this cycle's write lands, so a
    // collision returns the old contents.
    always_ff @(posedge clk_in)
    begin
        for (int p = 0; p < 2; p++)
        begin
            if (access_en[p])
            begin
                for (int l = 0; l < num_lane; l++)
                begin
                    if (write_en[p][l])
                    begin
                        mem[set_addr[p]][l*byte_len +: byte_len] <=
                            write_word[p][l*byte_len +: byte_len];
                    end
                end
                read_word[p] <= mem[set_addr[p]];
            end
        end
    end

    assign a_read_entry = entry_t'(read_word[0][entry_width-1:0]);
    assign b_read_entry = entry_t'(read_word[1][entry_width-1:0]);

    // ------------------------------
    // Valid bits
    // ------------------------------

    if (with_valid_array == "Yes")
    begin : g_valid
        logic [num_set-1:0] valid_bits;
        logic [1:0]         read_valid_q;

        always_ff @(posedge clk_in or posedge reset_in)
        begin
            if (reset_in)
            begin
                valid_bits <= '0;
                read_valid_q <= '0;
            end
            else
            begin
                for (int p = 0; p < 2; p++)
                begin
                    // Any lane written marks the set as filled.
                    if (access_en[p] && |write_en[p])
                    begin
                        valid_bits[set_addr[p]] <= 1'b1;
                    end
                    read_valid_q[p] <= access_en[p] && valid_bits[set_addr[p]];
                end
            end
        end

        assign a_read_valid = read_valid_q[0];
        assign b_read_valid = read_valid_q[1];
    end
    else
    begin : g_no_valid
        // Without per-set bits every entry counts as valid outside reset.
        assign a_read_valid = !reset_in;
        assign b_read_valid = !reset_in;
    end

endmodule

`default_nettype wire
